/* logic/cps_consts.svh */
//--------------------------------------------------------------------------
// Screen geometry and configuration register map of the tile video path.
// The geometry is far smaller than a real CPS screen so that a frame
// simulates quickly. Counters are 6 bits wide, so totals must stay <= 64.
//--------------------------------------------------------------------------
`ifndef CPS_CONSTS_SVH
`define CPS_CONSTS_SVH

// Horizontal timing in pixels
`define CPS_H_TOTAL     64
`define CPS_H_ACTIVE    48
`define CPS_HS_START    52
`define CPS_HS_END      56

// Vertical timing in lines
`define CPS_V_TOTAL     40
`define CPS_V_ACTIVE    32
`define CPS_VS_START    34
`define CPS_VS_END      36

// Addresses 0 to 15 select palette entries
`define CPS_REG_HSCROLL 5'd16
`define CPS_REG_VSCROLL 5'd17

`endif

/* logic/cps_pkg.sv */
//--------------------------------------------------------------------------
// Types shared by the video stages and the top level.
// Blanking levels are active high while the beam is in the visible area.
// A ROM word address is a row of 8 bits above a column of 5 bits.
//--------------------------------------------------------------------------
package cps_pkg;

    // Video sync and blanking levels
    typedef struct packed {
        logic lhbl;
        logic lvbl;
        logic hs;
        logic vs;
    } sync_t;

    typedef logic [3:0] colour_idx_t;

    // One palette entry, 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } pal_entry_t;

    typedef logic [4:0] cfg_addr_t;

    typedef struct packed {
        logic [7:0] row;
        logic [4:0] col;
    } rom_addr_t;

endpackage

/* logic/video_ifs.sv */
//--------------------------------------------------------------------------
// Stage-to-stage links of the video pipeline.
// No handshake on any of them. cen marks the clock of each pixel and the
// other signals are levels that change only on cen cycles.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

// Timing generator to tile fetch
interface timing_if;
    import cps_pkg::*;

    logic       cen;
    sync_t      sync;
    logic [5:0] hpos;
    logic [5:0] vpos;

    modport src (output cen, sync, hpos, vpos);
    modport dst (input cen, sync, hpos, vpos);
endinterface

// Tile fetch to planar decoder
interface tile_if;
    import cps_pkg::*;

    logic        cen;
    sync_t       sync;
    logic        load;
    logic [31:0] planes;

    modport src (output cen, sync, load, planes);
    modport dst (input cen, sync, load, planes);
endinterface

// Planar decoder to palette
interface pix_if;
    import cps_pkg::*;

    logic        cen;
    sync_t       sync;
    colour_idx_t idx;

    modport src (output cen, sync, idx);
    modport dst (input cen, sync, idx);
endinterface

/* logic/video_timing.sv */
//--------------------------------------------------------------------------
// Pixel enable at half the clock rate, beam counters and sync decoding.
// After reset the beam sits at the start of vertical blanking, so a full
// blanking interval passes before the first visible line.
// hpos, vpos and sync always describe the same pixel.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "cps_consts.svh"

module video_timing (
    input  logic  VB,
    input  logic  rst_n,
    timing_if.src tim
);
    import cps_pkg::*;

    localparam logic [5:0] H_LAST   = 6'(`CPS_H_TOTAL - 1);
    localparam logic [5:0] V_LAST   = 6'(`CPS_V_TOTAL - 1);
    localparam logic [5:0] H_ACT    = 6'(`CPS_H_ACTIVE);
    localparam logic [5:0] V_ACT    = 6'(`CPS_V_ACTIVE);
    localparam logic [5:0] HS_START = 6'(`CPS_HS_START);
    localparam logic [5:0] HS_END   = 6'(`CPS_HS_END);
    localparam logic [5:0] VS_START = 6'(`CPS_VS_START);
    localparam logic [5:0] VS_END   = 6'(`CPS_VS_END);

    logic       cen_q;
    logic [5:0] hcnt;
    logic [5:0] vcnt;
    logic [5:0] hcnt_nxt;
    logic [5:0] vcnt_nxt;
    sync_t      sync_nxt;
    sync_t      sync_q;

    // Pixel enable, every second clock
    always_ff @(posedge VB) begin
        if (!rst_n)
            cen_q <= 1'b0;
        else
            cen_q <= ~cen_q;
    end

    // Sync is decoded from the next position so it lines up with the counters
    always_comb begin
        hcnt_nxt = (hcnt == H_LAST) ? 6'd0 : hcnt + 6'd1;
        vcnt_nxt = vcnt;
        if (hcnt == H_LAST)
            vcnt_nxt = (vcnt == V_LAST) ? 6'd0 : vcnt + 6'd1;
        sync_nxt.lhbl = hcnt_nxt < H_ACT;
        sync_nxt.lvbl = vcnt_nxt < V_ACT;
        sync_nxt.hs   = hcnt_nxt >= HS_START && hcnt_nxt < HS_END;
        sync_nxt.vs   = vcnt_nxt >= VS_START && vcnt_nxt < VS_END;
    end

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            // First cen lands on pixel 0 of the first blank line
            hcnt   <= H_LAST;
            vcnt   <= V_ACT - 6'd1;
            sync_q <= '0;
        end else if (cen_q) begin
            hcnt   <= hcnt_nxt;
            vcnt   <= vcnt_nxt;
            sync_q <= sync_nxt;
        end
    end

    assign tim.cen  = cen_q;
    assign tim.sync = sync_q;
    assign tim.hpos = hcnt;
    assign tim.vpos = vcnt;

endmodule

/* logic/tile_fetch.sv */
//--------------------------------------------------------------------------
// Graphics ROM fetch, one 32-bit planar word per 8-pixel column.
// The next column is requested on the first pixel of the current one, so
// the ROM has 16 clocks to answer. A late answer is dropped and the column
// is shown as index 0. Scroll is coarse, in whole columns and whole lines.
// The last column slot of a line fetches column 0 of the following line.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "cps_consts.svh"

module tile_fetch (
    input  logic               VB,
    input  logic               rst_n,
    timing_if.dst              tim,
    tile_if.src                til,
    output logic               rom_cs,
    output cps_pkg::rom_addr_t rom_addr,
    input  logic [31:0]        rom_data,
    input  logic               rom_ok,
    input  logic               cfg_we,
    input  cps_pkg::cfg_addr_t cfg_addr,
    input  logic [15:0]        cfg_data
);
    import cps_pkg::*;

    localparam logic [5:0] V_LAST = 6'(`CPS_V_TOTAL - 1);

    logic [4:0]  hscroll;
    logic [7:0]  vscroll;
    logic        col_start;
    logic        last_col;
    logic [2:0]  next_col;
    logic [5:0]  next_line;
    rom_addr_t   next_addr;
    logic        rom_hit;
    logic        restart;
    logic        word_vld;
    logic [31:0] word_buf;
    logic [31:0] planes_q;
    logic        load_q;
    sync_t       sync_q;

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            hscroll <= '0;
            vscroll <= '0;
        end else if (cfg_we) begin
            if (cfg_addr == `CPS_REG_HSCROLL)
                hscroll <= cfg_data[4:0];
            if (cfg_addr == `CPS_REG_VSCROLL)
                vscroll <= cfg_data[7:0];
        end
    end

    assign col_start = tim.cen && tim.hpos[2:0] == 3'd0;
    assign last_col  = &tim.hpos[5:3];
    // Column slot wraps within the line
    assign next_col  = tim.hpos[5:3] + 3'd1;
    assign rom_hit   = rom_cs && rom_ok;

    always_comb begin
        next_line = tim.vpos;
        if (last_col)
            next_line = (tim.vpos == V_LAST) ? 6'd0 : tim.vpos + 6'd1;
        next_addr.row = {2'b00, next_line} + vscroll;
        next_addr.col = {2'b00, next_col} + hscroll;
    end

    // Request control
    always_ff @(posedge VB) begin
        if (!rst_n) begin
            rom_cs   <= 1'b0;
            restart  <= 1'b0;
            word_vld <= 1'b0;
        end else if (col_start) begin
            // Open request at the boundary is abandoned, cs low for a cycle
            rom_cs   <= ~(rom_cs && !rom_ok);
            restart  <= rom_cs && !rom_ok;
            word_vld <= 1'b0;
        end else if (restart) begin
            rom_cs  <= 1'b1;
            restart <= 1'b0;
        end else if (rom_hit) begin
            rom_cs   <= 1'b0;
            word_vld <= 1'b1;
        end
    end

    always_ff @(posedge VB) begin
        if (col_start)
            rom_addr <= next_addr;
        if (rom_hit)
            word_buf <= rom_data;
        // An answer on the boundary cycle itself still counts
        if (col_start)
            planes_q <= rom_hit ? rom_data : (word_vld ? word_buf : 32'd0);
    end

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            load_q <= 1'b0;
            sync_q <= '0;
        end else if (tim.cen) begin
            load_q <= col_start;
            sync_q <= tim.sync;
        end
    end

    assign til.cen    = tim.cen;
    assign til.sync   = sync_q;
    assign til.load   = load_q;
    assign til.planes = planes_q;

endmodule

/* logic/planar_decode.sv */
//--------------------------------------------------------------------------
// Planar to packed pixel conversion.
// Byte n of a word holds plane n, and the leftmost pixel sits in bit 7.
// The first pixel of a column leaves on the same cen that loads the word.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module planar_decode (
    input  logic VB,
    input  logic rst_n,
    tile_if.dst  til,
    pix_if.src   pix
);
    import cps_pkg::*;

    logic [3:0][7:0] plane_sr;
    colour_idx_t     idx_q;
    sync_t           sync_q;

    always_ff @(posedge VB) begin
        if (til.cen) begin
            if (til.load) begin
                idx_q <= {til.planes[31], til.planes[23], til.planes[15], til.planes[7]};
                // Keep what is left after pixel 0
                for (int i = 0; i < 4; i++)
                    plane_sr[i] <= {til.planes[8*i +: 7], 1'b0};
            end else begin
                idx_q <= {plane_sr[3][7], plane_sr[2][7], plane_sr[1][7], plane_sr[0][7]};
                for (int i = 0; i < 4; i++)
                    plane_sr[i] <= {plane_sr[i][6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge VB) begin
        if (!rst_n)
            sync_q <= '0;
        else if (til.cen)
            sync_q <= til.sync;
    end

    assign pix.cen  = til.cen;
    assign pix.sync = sync_q;
    assign pix.idx  = idx_q;

endmodule

/* logic/palette_out.sv */
//--------------------------------------------------------------------------
// Palette lookup and final colour output.
// 16 entries of 12 bits, written from the configuration port. Contents are
// undefined until software writes them. Channels are widened to 8 bits by
// repeating the nibble, so 4'hf gives full scale.
// Colour is forced to black whenever either blanking level is low.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module palette_out (
    input  logic               VB,
    input  logic               rst_n,
    pix_if.dst                 pix,
    input  logic               cfg_we,
    input  cps_pkg::cfg_addr_t cfg_addr,
    input  logic [15:0]        cfg_data,
    output logic [7:0]         red,
    output logic [7:0]         green,
    output logic [7:0]         blue,
    output logic               lhbl_dly,
    output logic               lvbl_dly,
    output logic               hs_out,
    output logic               vs_out
);
    import cps_pkg::*;

    pal_entry_t pal_mem [16];
    pal_entry_t entry;
    logic       blank;

    // Palette occupies addresses 0 to 15, bit 4 clear
    always_ff @(posedge VB) begin
        if (cfg_we && !cfg_addr[4])
            pal_mem[cfg_addr[3:0]] <= pal_entry_t'(cfg_data[11:0]);
    end

    assign entry = pal_mem[pix.idx];
    assign blank = !(pix.sync.lhbl && pix.sync.lvbl);

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            red      <= '0;
            green    <= '0;
            blue     <= '0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            hs_out   <= 1'b0;
            vs_out   <= 1'b0;
        end else if (pix.cen) begin
            red      <= blank ? 8'd0 : {entry.r, entry.r};
            green    <= blank ? 8'd0 : {entry.g, entry.g};
            blue     <= blank ? 8'd0 : {entry.b, entry.b};
            lhbl_dly <= pix.sync.lhbl;
            lvbl_dly <= pix.sync.lvbl;
            hs_out   <= pix.sync.hs;
            vs_out   <= pix.sync.vs;
        end
    end

endmodule

/* logic/cps_video_top.sv */
//--------------------------------------------------------------------------
// Tile layer video path. Timing, ROM fetch, planar decode and palette.
// Outputs trail the beam counters by three pixels. The ROM port expects
// rom_ok as a one-cycle pulse while rom_cs is high. Configuration writes
// take effect at the next clock edge.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cps_video_top (
    input  logic               VB,
    input  logic               rst_n,
    // Graphics ROM
    output logic               rom_cs,
    output cps_pkg::rom_addr_t rom_addr,
    input  logic [31:0]        rom_data,
    input  logic               rom_ok,
    // Palette and scroll writes
    input  logic               cfg_we,
    input  cps_pkg::cfg_addr_t cfg_addr,
    input  logic [15:0]        cfg_data,
    // Video out
    output logic [7:0]         red,
    output logic [7:0]         green,
    output logic [7:0]         blue,
    output logic               lhbl_dly,
    output logic               lvbl_dly,
    output logic               hs_out,
    output logic               vs_out
);

    timing_if tim_if ();
    tile_if   til_if ();
    pix_if    pix_if0 ();

    video_timing u_timing (
        .VB    ( VB     ),
        .rst_n ( rst_n  ),
        .tim   ( tim_if )
    );

    tile_fetch u_fetch (
        .VB       ( VB       ),
        .rst_n    ( rst_n    ),
        .tim      ( tim_if   ),
        .til      ( til_if   ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .cfg_we   ( cfg_we   ),
        .cfg_addr ( cfg_addr ),
        .cfg_data ( cfg_data )
    );

    planar_decode u_decode (
        .VB    ( VB      ),
        .rst_n ( rst_n   ),
        .til   ( til_if  ),
        .pix   ( pix_if0 )
    );

    palette_out u_palette (
        .VB       ( VB       ),
        .rst_n    ( rst_n    ),
        .pix      ( pix_if0  ),
        .cfg_we   ( cfg_we   ),
        .cfg_addr ( cfg_addr ),
        .cfg_data ( cfg_data ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly ),
        .hs_out   ( hs_out   ),
        .vs_out   ( vs_out   )
    );

endmodule

/* tb/tb_cps_video.sv */
//--------------------------------------------------------------------------
// Testbench for the tile layer video path.
// A ROM responder answers each request after 1 to 6 clocks with data made
// from the address. Outputs are sampled on the falling clock edge and
// aligned on the rising edges of lhbl_dly and lvbl_dly. Config writes are
// made only in vertical blanking. Frame 3 withholds one column address.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "cps_consts.svh"

module tb_cps_video;
    import cps_pkg::*;

    localparam int FRAME_CYCLES   = `CPS_H_TOTAL * `CPS_V_TOTAL * 2;
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 1000;

    logic        VB;
    logic        rst_n;
    logic        rom_cs;
    rom_addr_t   rom_addr;
    logic [31:0] rom_data = 32'd0;
    logic        rom_ok = 1'b0;
    logic        cfg_we;
    cfg_addr_t   cfg_addr;
    logic [15:0] cfg_data;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic        lhbl_dly;
    logic        lvbl_dly;
    logic        hs_out;
    logic        vs_out;

    // Reference state
    logic [11:0] pal_m [16];
    logic [4:0]  hscroll_m;
    logic [7:0]  vscroll_m;
    logic        miss_on;
    logic [4:0]  miss_col;

    // Responder state
    logic      req_busy;
    logic      req_hold;
    int        req_wait;
    rom_addr_t req_addr;

    // Output tracking
    logic started;
    logic lhbl_q;
    logic lvbl_q;
    logic hs_q;
    logic vs_q;
    logic act_q;
    int   x_clk;
    int   line_y;
    int   lines_seen;
    int   hs_pulses;
    int   vs_pulses;
    int   frames_done;
    int   miss_px;
    int   checks;
    int   errors;
    int   cycles;

    cps_video_top dut0 (
        .VB       ( VB       ),
        .rst_n    ( rst_n    ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .cfg_we   ( cfg_we   ),
        .cfg_addr ( cfg_addr ),
        .cfg_data ( cfg_data ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly ),
        .hs_out   ( hs_out   ),
        .vs_out   ( vs_out   )
    );

    always #5 VB = ~VB;

    // Graphics word stored at a ROM address
    function automatic logic [31:0] rom_word(input logic [12:0] addr);
        logic [31:0] a;
        a = {19'd0, addr};
        return a * 32'h9e3779b1 + a;
    endfunction

    // Pixel p takes bit 7-p of each plane byte with plane 3 as the MSB
    function automatic logic [3:0] planar_index(input logic [31:0] word, input int p);
        int b;
        b = 7 - p;
        return {word[24 + b], word[16 + b], word[8 + b], word[b]};
    endfunction

    function automatic logic [23:0] expand_colour(input logic [11:0] e);
        return {e[11:8], e[11:8], e[7:4], e[7:4], e[3:0], e[3:0]};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic cfg_write(input logic [4:0] addr, input logic [15:0] data);
        @(posedge VB);
        #1;
        cfg_we   = 1'b1;
        cfg_addr = addr;
        cfg_data = data;
        @(posedge VB);
        #1;
        cfg_we = 1'b0;
        if (addr == `CPS_REG_HSCROLL)
            hscroll_m = data[4:0];
        else if (addr == `CPS_REG_VSCROLL)
            vscroll_m = data[7:0];
        else if (!addr[4])
            pal_m[addr[3:0]] = data[11:0];
    endtask

    // ROM responder serving one request at a time
    always @(posedge VB) begin
        #1;
        rom_ok = 1'b0;
        if (!rst_n || !rom_cs) begin
            req_busy = 1'b0;
        end else if (!req_busy) begin
            req_busy = 1'b1;
            req_addr = rom_addr;
            req_wait = int'($urandom % 6) + 1;
            req_hold = miss_on && rom_addr.col == miss_col;
        end else begin
            req_wait = req_wait - 1;
            if (req_wait == 0 && !req_hold) begin
                rom_ok   = 1'b1;
                rom_data = rom_word(req_addr);
                req_busy = 1'b0;
            end
        end
    end

    // Output checker sampling mid-cycle
    always @(negedge VB) begin : check_outputs
        logic       act;
        logic [7:0] row;
        logic [4:0] col;
        logic [3:0] idx;
        int         px;
        if (started) begin
            act = lhbl_dly && lvbl_dly;
            if (vs_out && !vs_q)
                vs_pulses++;
            if (hs_out && !hs_q)
                hs_pulses++;
            if (lhbl_dly && !lhbl_q) begin
                if (lvbl_dly)
                    compare_value("hs pulses before line", 32'd1, hs_pulses);
                hs_pulses = 0;
            end
            if (lvbl_dly && !lvbl_q) begin
                compare_value("vs pulses before frame", 32'd1, vs_pulses);
                vs_pulses = 0;
            end
            if (act && !act_q) begin
                line_y = lvbl_q ? line_y + 1 : 0;
                lines_seen++;
                x_clk = 0;
            end
            if (act) begin
                // Each pixel lasts two clocks and the first one is checked
                if (x_clk % 2 == 0) begin
                    px  = x_clk / 2;
                    row = 8'(line_y + int'(vscroll_m));
                    col = 5'(px / 8 + int'(hscroll_m));
                    if (miss_on && col == miss_col) begin
                        idx = 4'd0;
                        miss_px++;
                    end else begin
                        idx = planar_index(rom_word({row, col}), px % 8);
                    end
                    compare_value($sformatf("frame%0d pixel x=%0d y=%0d", frames_done + 1,
                                            px, line_y),
                                  {8'd0, expand_colour(pal_m[idx])}, {8'd0, red, green, blue});
                end
                x_clk++;
            end else begin
                compare_value("blanked rgb", 32'd0, {8'd0, red, green, blue});
            end
            if (!lhbl_dly && lhbl_q && lvbl_dly)
                compare_value("active pixels per line", `CPS_H_ACTIVE, x_clk / 2);
            if (!lvbl_dly && lvbl_q) begin
                compare_value("active lines per frame", `CPS_V_ACTIVE, lines_seen);
                lines_seen = 0;
                frames_done++;
            end
            lhbl_q = lhbl_dly;
            lvbl_q = lvbl_dly;
            hs_q   = hs_out;
            vs_q   = vs_out;
            act_q  = act;
        end
    end

    always @(posedge VB) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, only %0d frames seen", cycles, frames_done);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        VB          = 1'b0;
        rst_n       = 1'b0;
        cfg_we      = 1'b0;
        cfg_addr    = '0;
        cfg_data    = '0;
        hscroll_m   = '0;
        vscroll_m   = '0;
        miss_on     = 1'b0;
        miss_col    = '0;
        req_busy    = 1'b0;
        req_hold    = 1'b0;
        req_wait    = 0;
        req_addr    = '0;
        started     = 1'b0;
        lhbl_q      = 1'b0;
        lvbl_q      = 1'b0;
        hs_q        = 1'b0;
        vs_q        = 1'b0;
        act_q       = 1'b0;
        x_clk       = 0;
        line_y      = 0;
        lines_seen  = 0;
        hs_pulses   = 0;
        vs_pulses   = 0;
        frames_done = 0;
        miss_px     = 0;
        checks      = 0;
        errors      = 0;
        cycles      = 0;
        void'($urandom(32'h1ad));

        repeat (5) @(posedge VB);
        #1;
        rst_n = 1'b1;

        // Reset values while the beam is still in the first blanking interval
        compare_value("rom_cs after reset", 32'd0, {31'd0, rom_cs});
        compare_value("hs_out after reset", 32'd0, {31'd0, hs_out});
        compare_value("vs_out after reset", 32'd0, {31'd0, vs_out});
        compare_value("lhbl_dly after reset", 32'd0, {31'd0, lhbl_dly});
        compare_value("lvbl_dly after reset", 32'd0, {31'd0, lvbl_dly});
        compare_value("rgb after reset", 32'd0, {8'd0, red, green, blue});
        started = 1'b1;

        for (int i = 0; i < 16; i++)
            cfg_write(5'(i), 16'($urandom));

        // Frame 2 scrolled
        wait (frames_done == 1);
        cfg_write(`CPS_REG_HSCROLL, 16'($urandom));
        cfg_write(`CPS_REG_VSCROLL, 16'($urandom));

        // Frame 3 loses the third visible column and entry 0 is made visible
        wait (frames_done == 2);
        miss_col = hscroll_m + 5'd2;
        miss_on  = 1'b1;
        cfg_write(5'd0, 16'($urandom) | 16'h0111);

        wait (frames_done == 3);
        compare_value("missed column pixels", 32'(8 * `CPS_V_ACTIVE), miss_px);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* files.f */
+incdir+logic
logic/cps_pkg.sv
logic/video_ifs.sv
logic/video_timing.sv
logic/tile_fetch.sv
logic/planar_decode.sv
logic/palette_out.sv
logic/cps_video_top.sv
tb/tb_cps_video.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the tile video testbench with Verilator, runs it and scans the log.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -j 0 -f files.f --top-module tb_cps_video -Mdir "$BUILD_DIR"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/Vtb_cps_video" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG_FILE"; then
    echo "Failure reported in $LOG_FILE"
    exit 1
fi

echo "No failure found in $LOG_FILE"
exit 0
